//--- vlog.f
+incdir+include
hdl/cache_types_pkg.sv
hdl/store_buffer_pkg.sv
hdl/rr_arbiter.sv
hdl/store_request_decode.sv
hdl/store_entry_array.sv
hdl/store_dequeue_wake.sv
hdl/l1_store_buffer.sv
tests/store_buffer_tb.sv

//--- Bender.yml
package:
  name: l1_store_buffer

sources:
  - include_dirs:
      - include
    files:
      - hdl/cache_types_pkg.sv
      - hdl/store_buffer_pkg.sv
      - hdl/rr_arbiter.sv
      - hdl/store_request_decode.sv
      - hdl/store_entry_array.sv
      - hdl/store_dequeue_wake.sv
      - hdl/l1_store_buffer.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/store_buffer_tb.sv

//--- tests/store_buffer_tb.sv
`include "store_consts.svh"

module store_buffer_tb
	import cache_types_pkg::*;
	import store_buffer_pkg::*;
();

	localparam int TEST_CYCLES = 80;                         // Budget per test.
	localparam int WATCHDOG_CYCLES = 5 * TEST_CYCLES + 100;
	localparam int DRAIN_LIMIT = 40;

	logic clk = 1'b0;
	logic reset;
	logic store_en;
	store_req_t store_req;
	bypass_req_t bypass_req;
	bypass_rsp_t bypass_rsp;
	logic full_rollback;
	logic dequeue_ready;
	logic dequeue_ack;
	dequeue_req_t dequeue;
	logic wake_en;
	l1_miss_entry_idx_t wake_idx;
	logic [`THREADS_PER_CORE - 1:0] wake_oh;

	integer seed = 32'h1e2a_78a7;
	int errors = 0;
	int errors_before = 0;
	int passed = 0;
	int failed = 0;
	int ack_count[`THREADS_PER_CORE];
	store_entry_t model[`THREADS_PER_CORE];
	bypass_rsp_t exp_bypass;
	logic exp_rollback;
	logic hold;                 // Offer must stay as it was last cycle.
	thread_idx_t held_idx;

	l1_store_buffer i_dut (.*);

	always #10 clk = ~clk;

	function automatic cache_line_t write_bytes(input cache_line_t old, input cache_line_t data,
		input line_mask_t mask);
		cache_line_t result;
		result = old;
		for (int lane = 0; lane < `CACHE_LINE_BYTES; lane++)
		begin
			if (mask[lane])
				result[lane * 8 +: 8] = data[lane * 8 +: 8];
		end
		return result;
	endfunction

	function automatic cache_line_t random_line();
		cache_line_t line;
		for (int w = 0; w < `CACHE_LINE_BITS / 32; w++)
			line[w * 32 +: 32] = $random(seed);
		return line;
	endfunction

	// Small pool of lines so that stores collide.
	function automatic scalar_t pool_addr();
		return 32'h1000 + 32'h40 * ($unsigned($random(seed)) % 3);
	endfunction

	// Expected entries after this cycle's inputs, and the registered outputs for the next one.
	function automatic void apply_cycle(input logic ack, input thread_idx_t ack_idx);
		store_entry_t e;
		e = model[bypass_req.thread_idx];
		exp_bypass = (e.valid && e.address == bypass_req.addr)
			? bypass_rsp_t'{mask: e.mask, data: e.data} : '0;
		exp_rollback = 1'b0;
		if (store_en)
		begin
			e = model[store_req.thread_idx];
			if (!e.valid)
				e = '{valid: 1'b1, data: write_bytes('0, store_req.data, store_req.mask),
					mask: store_req.mask, address: store_req.addr,
					synchronized: store_req.synchronized, default: 1'b0};
			else if (e.address == store_req.addr && !e.synchronized && !store_req.synchronized
				&& !e.request_sent && !(ack && ack_idx == store_req.thread_idx))
			begin
				e.data = write_bytes(e.data, store_req.data, store_req.mask);
				e.mask = e.mask | store_req.mask;
			end
			else
			begin
				e.thread_waiting = 1'b1;
				exp_rollback = 1'b1;
			end
			model[store_req.thread_idx] = e;
		end
		if (ack)
			model[ack_idx].request_sent = 1'b1;
		if (wake_en)
			model[wake_idx] = '0;
	endfunction

	task automatic report_error(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic check_dequeue(input logic ready, input dequeue_req_t got,
		input logic [`THREADS_PER_CORE - 1:0] pending, input dequeue_req_t exp);
		got.data = write_bytes('0, got.data, got.mask);
		if (ready !== |pending || (ready && (!pending[got.idx] || got !== exp)))
			report_error($sformatf("dequeue ready %b thread %0d, expected thread %0d of pending %b",
				ready, got.idx, exp.idx, pending));
	endtask

	task automatic check_bypass(input bypass_rsp_t got, input bypass_rsp_t exp);
		if (got.mask !== exp.mask
			|| write_bytes('0, got.data, got.mask) !== write_bytes('0, exp.data, exp.mask))
			report_error($sformatf("bypass mask %h, expected %h, or data differs",
				got.mask, exp.mask));
	endtask

	task automatic check_rollback(input logic got, input logic exp);
		if (got !== exp)
			report_error($sformatf("full_rollback %b, expected %b", got, exp));
	endtask

	task automatic check_wake(input logic [`THREADS_PER_CORE - 1:0] got,
		input logic [`THREADS_PER_CORE - 1:0] exp);
		if (got !== exp)
			report_error($sformatf("wake_oh %b, expected %b", got, exp));
	endtask

	// Inputs and outputs are settled at the falling edge.
	always @(negedge clk)
	begin : compare_cycle
		logic [`THREADS_PER_CORE - 1:0] pending;
		logic [`THREADS_PER_CORE - 1:0] exp_wake;
		thread_idx_t offered;
		if (reset)
		begin
			model = '{default: '0};
			exp_bypass = '0;
			exp_rollback = 1'b0;
			hold = 1'b0;
		end
		else
		begin
			for (int t = 0; t < `THREADS_PER_CORE; t++)
				pending[t] = model[t].valid && !model[t].request_sent;
			offered = hold ? held_idx : dequeue.idx;    // Any order, but no switching unasked.
			exp_wake = '0;
			if (wake_en && model[wake_idx].thread_waiting)
				exp_wake[wake_idx] = 1'b1;
			check_dequeue(dequeue_ready, dequeue, pending, dequeue_req_t'{idx: offered,
				addr: model[offered].address, mask: model[offered].mask,
				data: write_bytes('0, model[offered].data, model[offered].mask)});
			check_bypass(bypass_rsp, exp_bypass);
			check_rollback(full_rollback, exp_rollback);
			check_wake(wake_oh, exp_wake);
			apply_cycle(dequeue_ack && dequeue_ready, offered);
			hold = dequeue_ready && !dequeue_ack && !store_en && !wake_en;
			held_idx = offered;
		end
	end

	task automatic send_store(input thread_idx_t t, input scalar_t addr, input logic sync);
		@(posedge clk);
		store_en <= 1'b1;
		store_req <= '{addr: addr, mask: {$random(seed), $random(seed)} | 64'h1,
			data: random_line(), synchronized: sync, thread_idx: t};
		bypass_req <= '{addr: addr, thread_idx: t};    // Look the line up as it lands.
		@(posedge clk);
		store_en <= 1'b0;
	endtask

	task automatic send_wake(input thread_idx_t t);
		@(posedge clk);
		wake_en <= 1'b1;
		wake_idx <= t;
		@(posedge clk);
		wake_en <= 1'b0;
	endtask

	// Ack whatever is offered, after a random pause, until nothing is left.
	task automatic drain_all();
		int waited;
		int delay;
		waited = 0;
		@(negedge clk);
		while (dequeue_ready && waited < DRAIN_LIMIT)
		begin
			delay = $unsigned($random(seed)) % 4;
			repeat (delay) @(posedge clk);
			@(posedge clk);
			dequeue_ack <= 1'b1;
			@(negedge clk);
			ack_count[dequeue.idx]++;
			@(posedge clk);
			dequeue_ack <= 1'b0;
			@(negedge clk);
			waited += delay + 2;
		end
		if (dequeue_ready)
			report_error($sformatf("stores were still offered to the ring after %0d cycles",
				waited));
	endtask

	task automatic clear_buffer();
		drain_all();
		for (int t = 0; t < `THREADS_PER_CORE; t++)
		begin
			if (model[t].valid)
				send_wake(thread_idx_t'(t));
		end
		repeat (2) @(posedge clk);
	endtask

	task automatic finish_test(input string name);
		if (errors == errors_before)
			passed++;
		else
			failed++;
		$display("%s: %s, %0d errors", name, (errors == errors_before) ? "passed" : "failed",
			errors - errors_before);
		errors_before = errors;
	endtask

	initial
	begin
		scalar_t a;
		reset <= 1'b1;
		store_en <= 1'b0;
		store_req <= '0;
		bypass_req <= '0;
		dequeue_ack <= 1'b0;
		wake_en <= 1'b0;
		wake_idx <= '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		for (int t = 0; t < `THREADS_PER_CORE; t++)
			send_store(thread_idx_t'(t), pool_addr(), 1'b0);
		clear_buffer();
		finish_test("new stores and bypass");

		a = pool_addr();
		send_store(2'd1, a, 1'b0);
		send_store(2'd1, a, 1'b0);
		clear_buffer();
		finish_test("write combining");

		a = pool_addr();
		send_store(2'd2, a, 1'b0);
		send_store(2'd2, a ^ 32'h40, 1'b0);     // Other line.
		send_store(2'd2, a, 1'b1);
		drain_all();
		send_store(2'd2, a, 1'b0);              // Already sent.
		clear_buffer();
		finish_test("rollback");

		ack_count = '{default: 0};
		for (int t = 0; t < `THREADS_PER_CORE; t++)
			send_store(thread_idx_t'(t), pool_addr(), 1'b0);
		drain_all();
		for (int t = 0; t < `THREADS_PER_CORE; t++)
		begin
			if (ack_count[t] != 1)
				report_error($sformatf("thread %0d went to the ring %0d times instead of once",
					t, ack_count[t]));
		end
		clear_buffer();
		finish_test("dequeue");

		a = pool_addr();
		send_store(2'd3, a, 1'b0);
		drain_all();
		send_store(2'd3, a ^ 32'h40, 1'b0);
		send_wake(2'd3);
		send_store(2'd3, a, 1'b0);
		send_store(2'd0, a, 1'b0);
		drain_all();
		send_wake(2'd0);                        // Thread 0 never waited.
		clear_buffer();
		finish_test("wake");

		$display("Tests passed: %0d, failed: %0d", passed, failed);
		if (failed == 0 && errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * 20);
		$display("Timed out after %0d cycles, the tests never finished", WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

endmodule

//--- hdl/l1_store_buffer.sv
`include "store_consts.svh"

module l1_store_buffer
	import cache_types_pkg::*;
	import store_buffer_pkg::*;
(
	input clk,
	input reset,

	// Data stage.
	input logic store_en,
	input store_req_t store_req,
	input bypass_req_t bypass_req,
	output bypass_rsp_t bypass_rsp,
	output logic full_rollback,

	// Ring controller and interconnect.
	output logic dequeue_ready,
	input logic dequeue_ack,
	output dequeue_req_t dequeue,
	input logic wake_en,
	input l1_miss_entry_idx_t wake_idx,
	output logic [`THREADS_PER_CORE - 1:0] wake_oh
);

	store_action_t action;
	store_entry_t entries[`THREADS_PER_CORE];
	logic [`THREADS_PER_CORE - 1:0] sent_oh;
	logic [`THREADS_PER_CORE - 1:0] retire_oh;

	store_request_decode i_decode (
		.store_en(store_en),
		.store_req(store_req),
		.entries(entries),
		.sent_oh(sent_oh),
		.action(action)
	);

	store_entry_array i_entries (
		.clk(clk),
		.reset(reset),
		.store_req(store_req),
		.action(action),
		.sent_oh(sent_oh),
		.retire_oh(retire_oh),
		.entries(entries)
	);

	store_dequeue_wake i_dequeue_wake (
		.clk(clk),
		.reset(reset),
		.entries(entries),
		.dequeue_ack(dequeue_ack),
		.bypass_req(bypass_req),
		.rollback_oh(action.rollback_oh),
		.wake_en(wake_en),
		.wake_idx(wake_idx),
		.dequeue_ready(dequeue_ready),
		.dequeue(dequeue),
		.sent_oh(sent_oh),
		.retire_oh(retire_oh),
		.bypass_rsp(bypass_rsp),
		.full_rollback(full_rollback),
		.wake_oh(wake_oh)
	);

endmodule

//--- hdl/store_dequeue_wake.sv
`include "store_consts.svh"

module store_dequeue_wake
	import cache_types_pkg::*;
	import store_buffer_pkg::*;
(
	input clk,
	input reset,
	input store_entry_t entries[`THREADS_PER_CORE],
	input logic dequeue_ack,
	input bypass_req_t bypass_req,
	input logic [`THREADS_PER_CORE - 1:0] rollback_oh,
	input logic wake_en,
	input l1_miss_entry_idx_t wake_idx,
	output logic dequeue_ready,
	output dequeue_req_t dequeue,
	output logic [`THREADS_PER_CORE - 1:0] sent_oh,
	output logic [`THREADS_PER_CORE - 1:0] retire_oh,
	output bypass_rsp_t bypass_rsp,
	output logic full_rollback,
	output logic [`THREADS_PER_CORE - 1:0] wake_oh
);

	logic [`THREADS_PER_CORE - 1:0] pending;
	logic [`THREADS_PER_CORE - 1:0] waiting;
	logic [`THREADS_PER_CORE - 1:0] grant_oh;
	l1_miss_entry_idx_t grant_idx;
	logic bypass_hit;
	line_mask_t bypass_mask_q;
	cache_line_t bypass_data_q;

	always_comb
	begin
		grant_idx = '0;
		for (int t = 0; t < `THREADS_PER_CORE; t++)
		begin
			pending[t] = entries[t].valid && !entries[t].request_sent;
			waiting[t] = entries[t].thread_waiting;
			if (grant_oh[t])
				grant_idx = l1_miss_entry_idx_t'(t);
		end
	end

	rr_arbiter #(
		.NUM_ENTRIES(`THREADS_PER_CORE)
	) i_send_arbiter (
		.clk(clk),
		.reset(reset),
		.request(pending),
		.update_lru(dequeue_ack),
		.grant_oh(grant_oh)
	);

	assign dequeue_ready = |grant_oh;
	assign dequeue = '{
		idx: grant_idx,
		addr: entries[grant_idx].address,
		mask: entries[grant_idx].mask,
		data: entries[grant_idx].data
	};
	assign sent_oh = dequeue_ack ? grant_oh : '0;

	assign retire_oh = wake_en ? (`THREADS_PER_CORE)'(1) << wake_idx : '0;
	assign wake_oh = retire_oh & waiting;

	assign bypass_hit = entries[bypass_req.thread_idx].valid
		&& entries[bypass_req.thread_idx].address == bypass_req.addr;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			bypass_mask_q <= '0;
			full_rollback <= 1'b0;
		end
		else
		begin
			bypass_mask_q <= bypass_hit ? entries[bypass_req.thread_idx].mask : '0;
			full_rollback <= |rollback_oh;
		end
	end

	always_ff @(posedge clk)
		bypass_data_q <= bypass_hit ? entries[bypass_req.thread_idx].data : '0;

	assign bypass_rsp = '{mask: bypass_mask_q, data: bypass_data_q};

	// Ring controller may only consume what is offered.
	ack_when_ready: assert property (@(posedge clk) disable iff (reset)
		dequeue_ack |-> dequeue_ready);

endmodule

//--- hdl/store_entry_array.sv
`include "store_consts.svh"

module store_entry_array
	import cache_types_pkg::*;
	import store_buffer_pkg::*;
(
	input clk,
	input reset,
	input store_req_t store_req,
	input store_action_t action,
	input logic [`THREADS_PER_CORE - 1:0] sent_oh,
	input logic [`THREADS_PER_CORE - 1:0] retire_oh,
	output store_entry_t entries[`THREADS_PER_CORE]
);

	logic [`THREADS_PER_CORE - 1:0] valid_q;
	logic [`THREADS_PER_CORE - 1:0] sent_q;
	logic [`THREADS_PER_CORE - 1:0] waiting_q;

	// Retire wins over everything else in the same cycle.
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			valid_q <= '0;
			sent_q <= '0;
			waiting_q <= '0;
		end
		else
		begin
			valid_q <= (valid_q | action.new_oh) & ~retire_oh;
			sent_q <= (sent_q | sent_oh) & ~action.new_oh & ~retire_oh;
			waiting_q <= (waiting_q | action.rollback_oh) & ~action.new_oh & ~retire_oh;
		end
	end

	genvar t;
	generate
		for (t = 0; t < `THREADS_PER_CORE; t++)
		begin : gen_entry
			cache_line_t data_q;
			line_mask_t mask_q;
			scalar_t addr_q;
			logic sync_q;
			logic write_en;

			assign write_en = action.new_oh[t] || action.combine_oh[t];

			always_ff @(posedge clk)
			begin
				if (write_en)
				begin
					for (int lane = 0; lane < `CACHE_LINE_BYTES; lane++)
					begin
						if (store_req.mask[lane])
							data_q[lane * 8 +: 8] <= store_req.data[lane * 8 +: 8];
					end

					// A combine keeps the bytes already pending.
					if (action.new_oh[t])
						mask_q <= store_req.mask;
					else
						mask_q <= mask_q | store_req.mask;
				end

				if (action.new_oh[t])
				begin
					addr_q <= store_req.addr;
					sync_q <= store_req.synchronized;
				end
			end

			assign entries[t] = '{
				valid: valid_q[t],
				data: data_q,
				mask: mask_q,
				address: addr_q,
				synchronized: sync_q,
				request_sent: sent_q[t],
				thread_waiting: waiting_q[t]
			};
		end
	endgenerate

	action_exclusive: assert property (@(posedge clk) disable iff (reset)
		$onehot0({action.new_oh, action.combine_oh, action.rollback_oh}));

	// The interconnect only wakes entries that were handed to the ring.
	retire_sent_only: assert property (@(posedge clk) disable iff (reset)
		(retire_oh & ~(valid_q & sent_q)) == '0);

endmodule

//--- hdl/store_request_decode.sv
`include "store_consts.svh"

module store_request_decode
	import cache_types_pkg::*;
	import store_buffer_pkg::*;
(
	input logic store_en,
	input store_req_t store_req,
	input store_entry_t entries[`THREADS_PER_CORE],
	input logic [`THREADS_PER_CORE - 1:0] sent_oh,
	output store_action_t action
);

	logic [`THREADS_PER_CORE - 1:0] new_oh;
	logic [`THREADS_PER_CORE - 1:0] combine_oh;
	logic [`THREADS_PER_CORE - 1:0] rollback_oh;

	genvar t;
	generate
		for (t = 0; t < `THREADS_PER_CORE; t++)
		begin : gen_thread
			logic store_this_entry;
			logic addr_match;
			logic no_sync;
			logic not_sent;
			logic can_combine;

			assign store_this_entry = store_en && store_req.thread_idx == thread_idx_t'(t);
			assign addr_match = entries[t].address == store_req.addr;

			// Synchronized stores need their own round trip.
			assign no_sync = !entries[t].synchronized && !store_req.synchronized;

			// An ack this cycle closes the entry to further combining.
			assign not_sent = !entries[t].request_sent && !sent_oh[t];

			assign can_combine = entries[t].valid && addr_match && no_sync && not_sent;

			assign new_oh[t] = store_this_entry && !entries[t].valid;
			assign combine_oh[t] = store_this_entry && can_combine;
			assign rollback_oh[t] = store_this_entry && entries[t].valid && !can_combine;
		end
	endgenerate

	assign action = '{
		new_oh: new_oh,
		combine_oh: combine_oh,
		rollback_oh: rollback_oh
	};

endmodule

//--- hdl/rr_arbiter.sv
module rr_arbiter #(
	parameter NUM_ENTRIES = 4
) (
	input clk,
	input reset,
	input logic [NUM_ENTRIES - 1:0] request,
	input logic update_lru,
	output logic [NUM_ENTRIES - 1:0] grant_oh
);

	localparam IDX_WIDTH = $clog2(NUM_ENTRIES);

	logic [IDX_WIDTH - 1:0] priority_idx;   // First entry to consider.
	logic [IDX_WIDTH - 1:0] grant_idx;

	// Scan from the priority pointer and take the first requester.
	always_comb
	begin
		logic found;
		int candidate;
		found = 1'b0;
		grant_oh = '0;
		grant_idx = '0;
		for (int offset = 0; offset < NUM_ENTRIES; offset++)
		begin
			candidate = (int'(priority_idx) + offset) % NUM_ENTRIES;
			if (!found && request[candidate])
			begin
				found = 1'b1;
				grant_oh[candidate] = 1'b1;
				grant_idx = IDX_WIDTH'(candidate);
			end
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			priority_idx <= '0;
		else if (update_lru && |grant_oh)
			priority_idx <= (grant_idx == IDX_WIDTH'(NUM_ENTRIES - 1)) ? '0 : grant_idx + 1'b1;
	end

	grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant_oh));

endmodule

//--- hdl/store_buffer_pkg.sv
`include "store_consts.svh"

package store_buffer_pkg;
	import cache_types_pkg::*;

	typedef struct packed {
		scalar_t addr;
		line_mask_t mask;
		cache_line_t data;
		logic synchronized;
		thread_idx_t thread_idx;
	} store_req_t;

	typedef struct packed {
		logic valid;
		cache_line_t data;
		line_mask_t mask;
		scalar_t address;
		logic synchronized;
		logic request_sent;     // Offered to the ring and acknowledged.
		logic thread_waiting;   // Thread was rolled back and needs a wake.
	} store_entry_t;

	// At most one bit set across all three vectors.
	typedef struct packed {
		logic [`THREADS_PER_CORE - 1:0] new_oh;
		logic [`THREADS_PER_CORE - 1:0] combine_oh;
		logic [`THREADS_PER_CORE - 1:0] rollback_oh;
	} store_action_t;

	typedef struct packed {
		l1_miss_entry_idx_t idx;
		scalar_t addr;
		line_mask_t mask;
		cache_line_t data;
	} dequeue_req_t;

	typedef struct packed {
		scalar_t addr;
		thread_idx_t thread_idx;
	} bypass_req_t;

	typedef struct packed {
		line_mask_t mask;
		cache_line_t data;
	} bypass_rsp_t;

endpackage

//--- hdl/cache_types_pkg.sv
`include "store_consts.svh"

package cache_types_pkg;

	// Line address as seen by the data stage and the ring.
	typedef logic [`ADDR_WIDTH - 1:0] scalar_t;

	typedef logic [`CACHE_LINE_BITS - 1:0] cache_line_t;

	// One enable per byte lane of a line.
	typedef logic [`CACHE_LINE_BYTES - 1:0] line_mask_t;

	typedef logic [$clog2(`THREADS_PER_CORE) - 1:0] thread_idx_t;

	// Store entries are owned one per thread, so the interconnect names
	// an entry by the thread number.
	typedef thread_idx_t l1_miss_entry_idx_t;

endpackage

//--- include/store_consts.svh
`ifndef STORE_CONSTS_SVH
`define STORE_CONSTS_SVH

// Hardware threads sharing one store buffer. One pending store each.
`define THREADS_PER_CORE 4

// Line geometry. The byte count sets the store mask width.
`define CACHE_LINE_BYTES 64
`define CACHE_LINE_BITS 512

`define ADDR_WIDTH 32

`endif
